/* dv/counter_input.txt */
# op a b c, all hex. W addr wdata sel | R addr mask expect | L la_en la_value expect
# C cycles 0 0 | I 0 0 irq | G mode arg expect (0 level, 1 steps, 2 after value, 3 at ack)
G 0 0 0000
I 0 0 0
R 00 FFFFFFFF 00000000
R 04 FFFFFFFF 00000000
R 08 FFFFFFFF 00000000
R 0C FFFFFFFF 00000000
# Byte selects on CMP and COUNT
W 08 0000AABB F
R 08 FFFFFFFF 0000AABB
W 08 000011CC 2
R 08 FFFFFFFF 000011BB
W 08 000033DD 1
R 08 FFFFFFFF 000011DD
W 08 FFFF0000 C
R 08 FFFFFFFF 000011DD
W 04 00001234 3
R 04 FFFFFFFF 00001234
W 04 0000AB00 2
R 04 FFFFFFFF 0000AB34
G 0 0 AB34
W 00 00000002 1
R 00 FFFFFFFF 00000002
# Count up, then hold
W 04 00000100 3
W 00 00000001 1
G 1 8 0001
W 00 00000000 1
G 1 8 0000
# Count down through zero
W 04 00000003 3
W 00 00000003 1
G 2 0000 FFFF
G 1 6 FFFF
W 00 00000000 1
G 1 4 0000
# Compare interrupt
W 08 00000010 3
W 04 00000008 3
I 0 0 0
W 00 00000001 1
C 20 0 0
I 0 0 1
R 0C FFFFFFFF 00000001
W 00 00000000 1
I 0 0 1
W 0C 00000001 1
I 0 0 0
R 0C FFFFFFFF 00000000
# Logic-analyzer load
W 04 00005500 3
L 00FF 12AB 55AB
L FFFF BEEF BEEF
W 04 00001357 3
G 3 0 1357
L 0000 0000 BEEF

/* sources.f */
+incdir+verilog
verilog/iob_counter_pkg.sv
verilog/iob_wishbone2iob.sv
verilog/iob_counter_regs.sv
verilog/iob_soc_caravel.sv
dv/tb_iob_soc_caravel.sv

/* Bender.yml */
package:
  name: iob_soc_caravel

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/iob_counter_pkg.sv
      - verilog/iob_wishbone2iob.sv
      - verilog/iob_counter_regs.sv
      - verilog/iob_soc_caravel.sv
  - target: simulation
    include_dirs:
      - verilog
    files:
      - dv/tb_iob_soc_caravel.sv

/* dv/tb_iob_soc_caravel.sv */
// Testbench for the Caravel counter project replaying operations from a vector file
`timescale 1ns/1ps
`include "iob_counter_macros.svh"

module tb_iob_soc_caravel
   import iob_counter_pkg::*;
();

   // Vector file path from the project root
   localparam INPUT_FILE = "dv/counter_input.txt";

   logic                    wb_clk_i;
   logic                    wb_rst_i;
   logic                    wbs_stb_i;
   logic                    wbs_cyc_i;
   logic                    wbs_we_i;
   logic [3:0]              wbs_sel_i;
   logic [`WB_DATA_W-1:0]   wbs_dat_i;
   logic [`WB_ADDR_W-1:0]   wbs_adr_i;
   logic                    wbs_ack_o;
   logic [`WB_DATA_W-1:0]   wbs_dat_o;
   logic [`LA_W-1:0]        la_data_in;
   logic [`LA_W-1:0]        la_data_out;
   logic [`LA_W-1:0]        la_oenb;
   logic [`CNT_BITS-1:0]    io_in;
   logic [`CNT_BITS-1:0]    io_out;
   logic [`CNT_BITS-1:0]    io_oeb;
   logic [`IRQ_W-1:0]       irq;
   int                      cycle_count;
   int                      cycle_limit = 0;
   // Pad value captured in the ack cycle of the last access
   logic [`CNT_BITS-1:0]    io_at_ack;

   iob_soc_caravel i_dut (
      .wb_clk_i    (wb_clk_i),
      .wb_rst_i    (wb_rst_i),
      .wbs_stb_i   (wbs_stb_i),
      .wbs_cyc_i   (wbs_cyc_i),
      .wbs_we_i    (wbs_we_i),
      .wbs_sel_i   (wbs_sel_i),
      .wbs_dat_i   (wbs_dat_i),
      .wbs_adr_i   (wbs_adr_i),
      .wbs_ack_o   (wbs_ack_o),
      .wbs_dat_o   (wbs_dat_o),
      .la_data_in  (la_data_in),
      .la_data_out (la_data_out),
      .la_oenb     (la_oenb),
      .io_in       (io_in),
      .io_out      (io_out),
      .io_oeb      (io_oeb),
      .irq         (irq)
   );

   // 8 ns clock
   initial begin
      wb_clk_i = 1'b0;
      forever begin
         #4 wb_clk_i = ~wb_clk_i;
      end
   end

   // Watchdog with its limit set once the vector file length is known
   initial begin : watchdog
      bridge_state_t st;
      cycle_count = 0;
      forever begin
         @(posedge wb_clk_i);
         cycle_count++;
         if (cycle_limit != 0 && cycle_count > cycle_limit) begin
            st = i_dut.i_bridge.state_q;
            $display("Timeout after %0d cycles, bridge stuck in %s", cycle_count, st.name());
            $display("=== FAIL ===");
            $fatal(1, "simulation timeout");
         end
      end
   end

   task automatic check_value(input string what, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s, got %h, expected %h", $time, what, actual, expected);
         $display("=== FAIL ===");
         $fatal(1, "value mismatch");
      end
   endtask

   task automatic drop_strobes();
      wbs_cyc_i = 1'b0;
      wbs_stb_i = 1'b0;
      wbs_we_i  = 1'b0;
      wbs_sel_i = 4'h0;
   endtask

   // Classic cycle with strobes held until the ack is seen at a falling edge
   task automatic wb_access(input logic we, input logic [31:0] addr,
                            input logic [31:0] data, input logic [3:0] sel,
                            output logic [31:0] rdata);
      @(negedge wb_clk_i);
      wbs_adr_i = addr;
      wbs_dat_i = data;
      wbs_sel_i = sel;
      wbs_we_i  = we;
      wbs_cyc_i = 1'b1;
      wbs_stb_i = 1'b1;
      do begin
         @(negedge wb_clk_i);
      end while (!wbs_ack_o);
      rdata     = wbs_dat_o;
      io_at_ack = io_out;
      drop_strobes();
   endtask

   // Enables are active low on the pins
   task automatic drive_la(input logic [15:0] en, input logic [15:0] la_value,
                           input logic [15:0] expected, input string what);
      @(negedge wb_clk_i);
      la_oenb[`LA_LOAD_LSB +: `CNT_BITS]    = ~en;
      la_data_in[`LA_LOAD_LSB +: `CNT_BITS] = la_value;
      @(negedge wb_clk_i);
      check_value({what, " io_out"}, io_out, expected);
      check_value({what, " la_data_out"}, la_data_out[`CNT_BITS-1:0], expected);
   endtask

   // Difference between consecutive sampled cycles modulo the width
   task automatic check_steps(input int n, input logic [15:0] step, input string what);
      logic [`CNT_BITS-1:0] prev;
      logic [`CNT_BITS-1:0] delta;
      @(negedge wb_clk_i);
      prev = io_out;
      repeat (n) begin
         @(negedge wb_clk_i);
         delta = io_out - prev;
         check_value(what, delta, step);
         prev = io_out;
      end
   endtask

   // Wait for one count value and check the next one
   task automatic count_after(input logic [15:0] seen, input logic [15:0] expected,
                              input string what);
      while (io_out !== seen) begin
         @(negedge wb_clk_i);
      end
      @(negedge wb_clk_i);
      check_value(what, io_out, expected);
   endtask

   task automatic stop_on_bad_line(input int line_no, input string why);
      $display("Vector file %s line %0d: %s", INPUT_FILE, line_no, why);
      $display("=== FAIL ===");
      $fatal(1, "bad vector file");
   endtask

   task automatic run_op(input logic [7:0] op, input logic [31:0] a, input logic [31:0] b,
                         input logic [31:0] c, input int line_no);
      reg_idx_t    idx;
      string       tag;
      logic [31:0] rdata;
      idx = reg_idx_t'(a[`REG_IDX_MSB:`REG_IDX_LSB]);
      tag = $sformatf("line %0d %c %s", line_no, op, idx.name());
      case (op)
         "W": wb_access(1'b1, a, b, c[3:0], rdata);
         "R": begin
            wb_access(1'b0, a, 32'h0, 4'hF, rdata);
            check_value({tag, " read"}, rdata & b, c);
         end
         "L": drive_la(a[15:0], b[15:0], c[15:0], tag);
         "C": repeat (a) @(negedge wb_clk_i);
         "I": check_value({tag, " irq"}, irq, c);
         "G": begin
            case (a)
               0: check_value({tag, " io_out"}, io_out, c);
               1: check_steps(b, c[15:0], {tag, " count step"});
               2: count_after(b[15:0], c[15:0], {tag, " count after value"});
               3: check_value({tag, " io_out at ack"}, io_at_ack, c);
               default: stop_on_bad_line(line_no, "unknown io_out check mode");
            endcase
         end
         default: stop_on_bad_line(line_no, "unknown operation");
      endcase
   endtask

   // Newline count plus one for a last line without a newline
   task automatic count_lines(output int n);
      int fd;
      int ch;
      n  = 1;
      fd = $fopen(INPUT_FILE, "r");
      if (fd == 0) begin
         stop_on_bad_line(0, "cannot open the file");
      end
      ch = $fgetc(fd);
      while (ch != -1) begin
         if (ch == 10) begin
            n++;
         end
         ch = $fgetc(fd);
      end
      $fclose(fd);
   endtask

   initial begin : main
      int          fd;
      int          ch;
      int          n_lines;
      int          line_no;
      int          n_fields;
      logic [7:0]  op;
      logic [31:0] arg_a;
      logic [31:0] arg_b;
      logic [31:0] arg_c;
      wb_rst_i   = 1'b1;
      wbs_adr_i  = '0;
      wbs_dat_i  = '0;
      la_data_in = '0;
      la_oenb    = '1;
      io_in      = '0;
      io_at_ack  = '0;
      drop_strobes();
      count_lines(n_lines);
      cycle_limit = 40 * n_lines + 200;
      // Pads tristated and no ack or irq while in reset
      repeat (4) @(negedge wb_clk_i);
      check_value("io_oeb in reset", io_oeb, 16'hFFFF);
      check_value("ack in reset", wbs_ack_o, 0);
      check_value("irq in reset", irq, 0);
      repeat (12) @(negedge wb_clk_i);
      wb_rst_i = 1'b0;
      @(negedge wb_clk_i);
      check_value("io_oeb after reset", io_oeb, 16'h0000);
      fd      = $fopen(INPUT_FILE, "r");
      line_no = 0;
      ch      = $fgetc(fd);
      while (ch != -1) begin
         line_no++;
         // First character is the op, comment and blank lines carry none
         if (ch != "#" && ch != 10 && ch != 13) begin
            op       = ch[7:0];
            n_fields = $fscanf(fd, "%h %h %h", arg_a, arg_b, arg_c);
            if (n_fields != 3) begin
               stop_on_bad_line(line_no, "expected an op and three fields");
            end
            run_op(op, arg_a, arg_b, arg_c, line_no);
         end
         // Rest of the line up to its newline
         while (ch != 10 && ch != -1) begin
            ch = $fgetc(fd);
         end
         ch = $fgetc(fd);
      end
      $fclose(fd);
      $display("=== PASS ===");
      $finish;
   end

endmodule

/* verilog/iob_soc_caravel.sv */
// User project top joining the Wishbone bridge and counter to the Caravel pins
`timescale 1ns/1ps
`default_nettype none
`include "iob_counter_macros.svh"

module iob_soc_caravel (
   // Wishbone slave port
   input  logic                    wb_clk_i,
   input  logic                    wb_rst_i,
   input  logic                    wbs_stb_i,
   input  logic                    wbs_cyc_i,
   input  logic                    wbs_we_i,
   input  logic [3:0]              wbs_sel_i,
   input  logic [`WB_DATA_W-1:0]   wbs_dat_i,
   input  logic [`WB_ADDR_W-1:0]   wbs_adr_i,
   output logic                    wbs_ack_o,
   output logic [`WB_DATA_W-1:0]   wbs_dat_o,
   // Logic analyzer
   input  logic [`LA_W-1:0]        la_data_in,
   output logic [`LA_W-1:0]        la_data_out,
   input  logic [`LA_W-1:0]        la_oenb,
   // GPIO pads, outputs only
   input  logic [`CNT_BITS-1:0]    io_in,
   output logic [`CNT_BITS-1:0]    io_out,
   output logic [`CNT_BITS-1:0]    io_oeb,
   // Interrupts
   output logic [`IRQ_W-1:0]       irq
);

   logic                    rst_n;
   logic                    bus_busy;
   logic                    iob_valid;
   logic [`WB_ADDR_W-1:0]   iob_address;
   logic [`WB_DATA_W-1:0]   iob_wdata;
   logic [3:0]              iob_wstrb;
   logic                    iob_ready;
   logic                    iob_rvalid;
   logic [`WB_DATA_W-1:0]   iob_rdata;
   logic [`CNT_BITS-1:0]    count;
   logic                    match_irq;

   // Caravel reset is active high
   assign rst_n    = ~wb_rst_i;
   // Blocks LA loads while the master owns the bus
   assign bus_busy = wbs_cyc_i & wbs_stb_i;

   iob_wishbone2iob i_bridge (
      .wb_clk_i      (wb_clk_i),
      .rst_n_i       (rst_n),
      .wbs_stb_i     (wbs_stb_i),
      .wbs_cyc_i     (wbs_cyc_i),
      .wbs_we_i      (wbs_we_i),
      .wbs_sel_i     (wbs_sel_i),
      .wbs_adr_i     (wbs_adr_i),
      .wbs_dat_i     (wbs_dat_i),
      .wbs_ack_o     (wbs_ack_o),
      .wbs_dat_o     (wbs_dat_o),
      .iob_valid_o   (iob_valid),
      .iob_address_o (iob_address),
      .iob_wdata_o   (iob_wdata),
      .iob_wstrb_o   (iob_wstrb),
      .iob_ready_i   (iob_ready),
      .iob_rvalid_i  (iob_rvalid),
      .iob_rdata_i   (iob_rdata)
   );

   iob_counter_regs i_counter (
      .wb_clk_i      (wb_clk_i),
      .rst_n_i       (rst_n),
      .iob_valid_i   (iob_valid),
      .iob_address_i (iob_address),
      .iob_wdata_i   (iob_wdata),
      .iob_wstrb_i   (iob_wstrb),
      .iob_ready_o   (iob_ready),
      .iob_rvalid_o  (iob_rvalid),
      .iob_rdata_o   (iob_rdata),
      .la_data_i     (la_data_in),
      .la_oenb_i     (la_oenb),
      .bus_busy_i    (bus_busy),
      .count_o       (count),
      .match_irq_o   (match_irq)
   );

   // Count on the pads, outputs enabled once out of reset
   assign io_out      = count;
   assign io_oeb      = {`CNT_BITS{wb_rst_i}};
   // Count mirrored on the low LA lines
   assign la_data_out = {{(`LA_W - `CNT_BITS){1'b0}}, count};
   // Only irq 0 in use
   assign irq         = {{(`IRQ_W - 1){1'b0}}, match_irq};

endmodule

`default_nettype wire

/* verilog/iob_counter_regs.sv */
// IOb register file around a 16-bit up/down counter with compare interrupt
`timescale 1ns/1ps
`default_nettype none
`include "iob_counter_macros.svh"

module iob_counter_regs
   import iob_counter_pkg::*;
(
   input  logic                    wb_clk_i,
   input  logic                    rst_n_i,
   // IOb slave side
   input  logic                    iob_valid_i,
   input  logic [`WB_ADDR_W-1:0]   iob_address_i,
   input  logic [`WB_DATA_W-1:0]   iob_wdata_i,
   input  logic [3:0]              iob_wstrb_i,
   output logic                    iob_ready_o,
   output logic                    iob_rvalid_o,
   output logic [`WB_DATA_W-1:0]   iob_rdata_o,
   // Logic analyzer load path
   input  logic [`LA_W-1:0]        la_data_i,
   input  logic [`LA_W-1:0]        la_oenb_i,
   input  logic                    bus_busy_i,
   // Outputs to pads and irq
   output logic [`CNT_BITS-1:0]    count_o,
   output logic                    match_irq_o
);

   reg_idx_t                reg_idx;
   logic                    wr_en;
   logic                    rd_en;
   logic                    run_q;
   logic                    down_q;
   logic [`CNT_BITS-1:0]    count_q;
   logic [`CNT_BITS-1:0]    count_d;
   logic [`CNT_BITS-1:0]    count_step;
   logic [`CNT_BITS-1:0]    cmp_q;
   logic                    status_q;
   logic                    status_clr;
   logic                    match_hit;
   logic [`CNT_BITS-1:0]    la_en;
   logic [`CNT_BITS-1:0]    la_val;
   logic                    rvalid_q;
   logic [`WB_DATA_W-1:0]   rdata_q;

   // Byte-lane merge of a bus write into a counter-wide register
   function automatic logic [`CNT_BITS-1:0] merge_bytes(
      input logic [`CNT_BITS-1:0]  old_v,
      input logic [`WB_DATA_W-1:0] wdata,
      input logic [3:0]            wstrb
   );
      logic [`CNT_BITS-1:0] res;
      res = old_v;
      for (int b = 0; b < `CNT_BITS / 8; b++) begin
         if (wstrb[b]) begin
            res[b*8 +: 8] = wdata[b*8 +: 8];
         end
      end
      return res;
   endfunction

   assign reg_idx = reg_idx_t'(iob_address_i[`REG_IDX_MSB:`REG_IDX_LSB]);
   // Zero strobe marks a read
   assign wr_en   = iob_valid_i & (|iob_wstrb_i);
   assign rd_en   = iob_valid_i & ~(|iob_wstrb_i);

   // Never stalls
   assign iob_ready_o = 1'b1;

   // Active-low LA enables, masked off while the bus is in use
   assign la_en  = ~la_oenb_i[`LA_LOAD_LSB +: `CNT_BITS] & {`CNT_BITS{~bus_busy_i}};
   assign la_val = la_data_i[`LA_LOAD_LSB +: `CNT_BITS];

   // Wraps naturally at the width
   assign count_step = down_q ? count_q - 1'b1 : count_q + 1'b1;

   always_comb begin
      count_d = run_q ? count_step : count_q;
      // LA lines override only their enabled bits
      if (|la_en) begin
         count_d = (la_val & la_en) | (count_d & ~la_en);
      end
      // Bus write replaces this cycle's step
      if (wr_en && reg_idx == COUNT) begin
         count_d = merge_bytes(count_q, iob_wdata_i, iob_wstrb_i);
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         count_q <= '0;
      end else begin
         count_q <= count_d;
      end
   end

   // Control register, byte 0 only
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         run_q  <= 1'b0;
         down_q <= 1'b0;
      end else if (wr_en && reg_idx == CTRL && iob_wstrb_i[0]) begin
         run_q  <= iob_wdata_i[`CTRL_RUN_BIT];
         down_q <= iob_wdata_i[`CTRL_DOWN_BIT];
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         cmp_q <= '0;
      end else if (wr_en && reg_idx == CMP) begin
         cmp_q <= merge_bytes(cmp_q, iob_wdata_i, iob_wstrb_i);
      end
   end

   // Compare only counts while running, so reset state stays quiet
   assign match_hit  = run_q & (count_q == cmp_q);
   assign status_clr = wr_en & (reg_idx == STATUS) & iob_wstrb_i[0]
                     & iob_wdata_i[`STAT_MATCH_BIT];

   // Sticky match, a new hit beats a same-cycle clear
   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         status_q <= 1'b0;
      end else if (match_hit) begin
         status_q <= 1'b1;
      end else if (status_clr) begin
         status_q <= 1'b0;
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         rvalid_q <= 1'b0;
      end else begin
         rvalid_q <= rd_en;
      end
   end

   // Read mux, registered one cycle after valid
   always_ff @(posedge wb_clk_i) begin
      if (rd_en) begin
         rdata_q <= '0;
         case (reg_idx)
            CTRL: begin
               rdata_q[`CTRL_RUN_BIT]  <= run_q;
               rdata_q[`CTRL_DOWN_BIT] <= down_q;
            end
            COUNT:   rdata_q[`CNT_BITS-1:0] <= count_q;
            CMP:     rdata_q[`CNT_BITS-1:0] <= cmp_q;
            STATUS:  rdata_q[`STAT_MATCH_BIT] <= status_q;
            default: rdata_q <= '0;
         endcase
      end
   end

   assign iob_rvalid_o = rvalid_q;
   assign iob_rdata_o  = rdata_q;
   assign count_o      = count_q;
   assign match_irq_o  = status_q;

   // Read response needs a read request the cycle before
   a_rvalid_after_read: assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i)
      iob_rvalid_o |-> $past(iob_valid_i && iob_wstrb_i == 4'b0000)
   );

   // Sticky bit drops only through a STATUS write
   a_status_clear_by_write: assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i)
      $fell(status_q) |-> $past(status_clr)
   );

endmodule

`default_nettype wire

/* verilog/iob_wishbone2iob.sv */
// Wishbone classic slave that turns each bus cycle into a single IOb transfer
`timescale 1ns/1ps
`default_nettype none
`include "iob_counter_macros.svh"

module iob_wishbone2iob
   import iob_counter_pkg::*;
(
   input  logic                    wb_clk_i,
   input  logic                    rst_n_i,
   // Wishbone slave side
   input  logic                    wbs_stb_i,
   input  logic                    wbs_cyc_i,
   input  logic                    wbs_we_i,
   input  logic [3:0]              wbs_sel_i,
   input  logic [`WB_ADDR_W-1:0]   wbs_adr_i,
   input  logic [`WB_DATA_W-1:0]   wbs_dat_i,
   output logic                    wbs_ack_o,
   output logic [`WB_DATA_W-1:0]   wbs_dat_o,
   // IOb master side
   output logic                    iob_valid_o,
   output logic [`WB_ADDR_W-1:0]   iob_address_o,
   output logic [`WB_DATA_W-1:0]   iob_wdata_o,
   output logic [3:0]              iob_wstrb_o,
   input  logic                    iob_ready_i,
   input  logic                    iob_rvalid_i,
   input  logic [`WB_DATA_W-1:0]   iob_rdata_i
);

   bridge_state_t           state_q;
   bridge_state_t           state_d;
   logic [`WB_ADDR_W-1:0]   addr_q;
   logic [`WB_DATA_W-1:0]   wdata_q;
   logic [3:0]              wstrb_q;
   logic                    we_q;
   logic [`WB_DATA_W-1:0]   rdata_q;
   logic                    wb_req;
   logic                    resp_done;

   // Classic cycle: request while both strobes are up
   assign wb_req = wbs_cyc_i & wbs_stb_i;

   // Writes finish on ready, reads on returned data
   assign resp_done = (state_q == RESP) & (we_q ? iob_ready_i : iob_rvalid_i);

   always_comb begin
      state_d = state_q;
      case (state_q)
         IDLE: begin
            if (wb_req) begin
               state_d = REQ;
            end
         end
         // Valid only lasts this one cycle
         REQ: state_d = RESP;
         RESP: begin
            if (resp_done) begin
               state_d = DONE;
            end
         end
         // Strobe still high here, so skip it
         DONE: state_d = IDLE;
         default: state_d = IDLE;
      endcase
   end

   always_ff @(posedge wb_clk_i) begin
      if (!rst_n_i) begin
         state_q <= IDLE;
      end else begin
         state_q <= state_d;
      end
   end

   // Latch the request when leaving IDLE
   always_ff @(posedge wb_clk_i) begin
      if (state_q == IDLE && wb_req) begin
         addr_q  <= wbs_adr_i;
         wdata_q <= wbs_dat_i;
         // Reads go out with an all-zero strobe
         wstrb_q <= wbs_sel_i & {4{wbs_we_i}};
         we_q    <= wbs_we_i;
      end
   end

   // Keep last read word for the data bus
   always_ff @(posedge wb_clk_i) begin
      if (iob_rvalid_i) begin
         rdata_q <= iob_rdata_i;
      end
   end

   assign iob_valid_o   = (state_q == REQ);
   assign iob_address_o = addr_q;
   assign iob_wdata_o   = wdata_q;
   assign iob_wstrb_o   = wstrb_q;

   // One-cycle ack pulse
   assign wbs_ack_o = resp_done;
   // Fresh data passes straight through in the ack cycle
   assign wbs_dat_o = iob_rvalid_i ? iob_rdata_i : rdata_q;

   // One IOb request per bus cycle
   a_valid_single: assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i)
      iob_valid_o |=> !iob_valid_o
   );

   // Ack only from RESP and always followed by DONE
   a_ack_in_resp: assert property (
      @(posedge wb_clk_i) disable iff (!rst_n_i)
      wbs_ack_o |-> (state_q == RESP) ##1 (state_q == DONE)
   );

endmodule

`default_nettype wire

/* verilog/iob_counter_pkg.sv */
// Shared types for the Wishbone to IOb bridge and the counter register file
package iob_counter_pkg;

   // Bridge sequencing, one IOb transfer per Wishbone cycle
   typedef enum logic [1:0] {
      // Waiting for cyc and stb
      IDLE = 2'd0,
      // IOb valid high for one cycle
      REQ  = 2'd1,
      // Waiting for ready (write) or rvalid (read)
      RESP = 2'd2,
      // Ack cycle done, master drops stb here
      DONE = 2'd3
   } bridge_state_t;

   // Register select from address bits 3:2
   typedef enum logic [1:0] {
      // Run and direction bits
      CTRL   = 2'd0,
      // Live counter value
      COUNT  = 2'd1,
      // Compare value for the match interrupt
      CMP    = 2'd2,
      // Sticky match, write 1 to clear
      STATUS = 2'd3
   } reg_idx_t;

endpackage

/* verilog/iob_counter_macros.svh */
// Widths, register map and bit positions of the counter peripheral
`ifndef IOB_COUNTER_MACROS_SVH
`define IOB_COUNTER_MACROS_SVH

// Bus and pad widths
`define WB_DATA_W      32
`define WB_ADDR_W      32
`define CNT_BITS       16
`define LA_W           128
`define IRQ_W          3

// Byte offsets of the registers
`define CTRL_OFFSET    8'h00
`define COUNT_OFFSET   8'h04
`define CMP_OFFSET     8'h08
`define STATUS_OFFSET  8'h0C

// Register index field inside the address
`define REG_IDX_MSB    3
`define REG_IDX_LSB    2

// Control and status bits
`define CTRL_RUN_BIT   0
`define CTRL_DOWN_BIT  1
`define STAT_MATCH_BIT 0

// First LA line carrying the count load value
`define LA_LOAD_LSB    48

`endif
